// File: logic/exec_pkg.sv
package exec_pkg;

    // width of the data fields in the structs below
    localparam int DATA_W = 64;

    // operation codes, any code not listed here yields zero
    typedef enum logic [4:0] {
        op_add    = 5'd0,
        op_sub    = 5'd1,
        op_pass_a = 5'd2,
        op_pass_b = 5'd3,
        op_xor    = 5'd4,
        op_or     = 5'd5,
        op_and    = 5'd6,
        op_sll    = 5'd7,
        op_srl    = 5'd8,
        op_sra    = 5'd9,
        op_slt    = 5'd10,
        op_sltu   = 5'd11,
        op_eq     = 5'd12,
        op_ge     = 5'd13,
        op_geu    = 5'd14,
        op_mul    = 5'd15,
        op_div    = 5'd16,
        op_divu   = 5'd17,
        op_rem    = 5'd18,
        op_remu   = 5'd19
    } alu_op_e;

    // operand a source
    typedef enum logic [1:0] {
        sel_a_pc  = 2'd0,
        sel_a_rs1 = 2'd1
    } sel_a_e;

    // operand b source, code 3 is not legal
    typedef enum logic [1:0] {
        sel_b_imm = 2'd0,
        sel_b_rs2 = 2'd1,
        sel_b_csr = 2'd2
    } sel_b_e;

    typedef struct packed {
        alu_op_e           op;
        logic [DATA_W-1:0] pc;
        logic [DATA_W-1:0] rs1;
        logic [DATA_W-1:0] rs2;
        logic [DATA_W-1:0] csr;
        logic [DATA_W-1:0] imm;
        sel_a_e            sel_a;
        sel_b_e            sel_b;
        // zero-extend rs1[31:0], sra works on the low word
        logic              word;
    } issue_t;

    typedef struct packed {
        alu_op_e           op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic              word;
    } operands_t;

    typedef struct packed {
        logic [DATA_W-1:0] res;
    } result_t;

    // division rule
    //   div, divu by zero give all ones
    //   rem, remu by zero give the dividend
    //   signed min / -1 gives min for div and zero for rem
    localparam logic [DATA_W-1:0] DIV_ZERO_QUOT = '1;
    localparam logic [DATA_W-1:0] SIGNED_MIN    = {1'b1, {(DATA_W-1){1'b0}}};
    localparam logic [DATA_W-1:0] MINUS_ONE     = '1;
    localparam logic [DATA_W-1:0] OVF_REM       = '0;

endpackage

// File: logic/operand_select.sv
`timescale 1ns/1ps

module operand_select #(
    parameter int XLEN = 64
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                issue_valid,
    input  exec_pkg::issue_t    issue,
    input  logic                busy,
    output logic                op_valid,
    output exec_pkg::operands_t operands
);

    logic            accept;
    logic [XLEN-1:0] a_sel;
    logic [XLEN-1:0] b_sel;

    // upstream holds off while busy, anything presented then is dropped
    assign accept = issue_valid && !busy;

    always_comb begin
        if (issue.sel_a == exec_pkg::sel_a_rs1) begin
            a_sel = issue.word ? {{(XLEN-32){1'b0}}, issue.rs1[31:0]} : issue.rs1;
        end else begin
            a_sel = issue.pc;
        end
        case (issue.sel_b)
            exec_pkg::sel_b_rs2: b_sel = issue.rs2;
            exec_pkg::sel_b_csr: b_sel = issue.csr;
            default:             b_sel = issue.imm;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= accept && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            operands <= '{op: issue.op, a: a_sel, b: b_sel, word: issue.word};
        end
    end

    // a decoder upstream must never emit the spare sel_b code
    a_sel_b_legal: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> (issue.sel_b inside {exec_pkg::sel_b_imm, exec_pkg::sel_b_rs2,
                                             exec_pkg::sel_b_csr}));

endmodule

// File: logic/iter_multiplier.sv
`timescale 1ns/1ps

module iter_multiplier #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            start,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic            done,
    output logic [XLEN-1:0] product
);

    localparam int CNT_W = $clog2(XLEN);

    logic             running;
    logic [CNT_W-1:0] step;
    logic [XLEN-1:0]  mcand;
    logic [XLEN-1:0]  mplier;
    logic [XLEN-1:0]  acc;
    logic [XLEN-1:0]  acc_next;
    logic             last_step;

    // only the low XLEN bits are kept, so upper partial sums just drop off
    assign acc_next  = mplier[0] ? acc + mcand : acc;
    assign last_step = (step == CNT_W'(XLEN - 1));
    assign product   = acc;

    // control
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            running <= 1'b0;
            step    <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!running) begin
                if (start) begin
                    running <= 1'b1;
                    step    <= '0;
                end
            end else begin
                step <= step + 1'b1;
                if (last_step) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // datapath, one multiplier bit per cycle
    always_ff @(posedge clk) begin
        if (!running && start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (running) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // exec_alu waits for done before it starts another product
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !running);

endmodule

// File: logic/exec_alu.sv
`timescale 1ns/1ps

module exec_alu #(
    parameter int XLEN = 64
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                op_valid,
    input  exec_pkg::operands_t operands,
    output logic                busy,
    output logic                res_valid,
    output exec_pkg::result_t   result
);

    logic            accept;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [5:0]      shamt;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] quot_s;
    logic [XLEN-1:0] rem_s;
    logic [31:0]     sra_word;
    logic            div_zero;
    logic            div_ovf;
    logic            mul_start;
    logic            mul_done;
    logic [XLEN-1:0] mul_a;
    logic [XLEN-1:0] mul_b;
    logic [XLEN-1:0] mul_product;

    if (XLEN != exec_pkg::DATA_W) begin : g_width_check
        $error("XLEN must equal exec_pkg::DATA_W");
    end

    assign a      = operands.a;
    assign b      = operands.b;
    assign shamt  = b[5:0];
    assign accept = op_valid && !flush && !busy;

    // signed quotient and remainder
    assign quot_s   = $signed(a) / $signed(b);
    assign rem_s    = $signed(a) % $signed(b);
    assign sra_word = $signed(a[31:0]) >>> shamt;
    assign div_zero = (b == '0);
    assign div_ovf  = (a == XLEN'(exec_pkg::SIGNED_MIN)) && (b == XLEN'(exec_pkg::MINUS_ONE));

    always_comb begin
        case (operands.op)
            exec_pkg::op_add:    alu_res = a + b;
            exec_pkg::op_sub:    alu_res = a - b;
            exec_pkg::op_pass_a: alu_res = a;
            exec_pkg::op_pass_b: alu_res = b;
            exec_pkg::op_xor:    alu_res = a ^ b;
            exec_pkg::op_or:     alu_res = a | b;
            exec_pkg::op_and:    alu_res = a & b;
            exec_pkg::op_sll:    alu_res = a << shamt;
            exec_pkg::op_srl:    alu_res = a >> shamt;
            exec_pkg::op_sra: begin
                // word form zero-extends the 32-bit result
                if (operands.word) begin
                    alu_res = {{(XLEN-32){1'b0}}, sra_word};
                end else begin
                    alu_res = $signed(a) >>> shamt;
                end
            end
            exec_pkg::op_slt:    alu_res = XLEN'($signed(a) < $signed(b));
            exec_pkg::op_sltu:   alu_res = XLEN'(a < b);
            exec_pkg::op_eq:     alu_res = XLEN'(a == b);
            exec_pkg::op_ge:     alu_res = XLEN'($signed(a) >= $signed(b));
            exec_pkg::op_geu:    alu_res = XLEN'(a >= b);
            exec_pkg::op_div: begin
                if (div_zero)     alu_res = XLEN'(exec_pkg::DIV_ZERO_QUOT);
                else if (div_ovf) alu_res = XLEN'(exec_pkg::SIGNED_MIN);
                else              alu_res = quot_s;
            end
            exec_pkg::op_divu:   alu_res = div_zero ? XLEN'(exec_pkg::DIV_ZERO_QUOT) : a / b;
            exec_pkg::op_rem: begin
                if (div_zero)     alu_res = a;
                else if (div_ovf) alu_res = XLEN'(exec_pkg::OVF_REM);
                else              alu_res = rem_s;
            end
            exec_pkg::op_remu:   alu_res = div_zero ? a : a % b;
            // mul goes through the multiplier and spare codes give zero
            default:             alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            mul_start <= 1'b0;
            res_valid <= 1'b0;
            result    <= '0;
        end else begin
            mul_start <= 1'b0;
            res_valid <= 1'b0;
            if (busy) begin
                if (flush) begin
                    busy <= 1'b0;
                end else if (mul_done) begin
                    busy       <= 1'b0;
                    res_valid  <= 1'b1;
                    result.res <= mul_product;
                end
            end else if (accept) begin
                if (operands.op == exec_pkg::op_mul) begin
                    busy      <= 1'b1;
                    mul_start <= 1'b1;
                end else begin
                    res_valid  <= 1'b1;
                    result.res <= alu_res;
                end
            end
        end
    end

    // operands held for the whole multiply
    always_ff @(posedge clk) begin
        if (accept && operands.op == exec_pkg::op_mul) begin
            mul_a <= a;
            mul_b <= b;
        end
    end

    iter_multiplier #(
        .XLEN (XLEN)
    ) iter_multiplier_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .start   (mul_start),
        .a       (mul_a),
        .b       (mul_b),
        .done    (mul_done),
        .product (mul_product)
    );

    // a product only comes back for a multiply still in flight
    a_done_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        mul_done |-> busy);

    // operand_select and the producer upstream both hold off while busy
    a_no_op_busy: assert property (@(posedge clk) disable iff (!rst_n)
        op_valid |-> !busy);

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit #(
    parameter int XLEN = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              issue_valid,
    input  exec_pkg::issue_t  issue,
    output logic              busy,
    output logic              res_valid,
    output exec_pkg::result_t result
);

    logic                op_valid;
    exec_pkg::operands_t operands;

    operand_select #(
        .XLEN (XLEN)
    ) operand_select_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue       (issue),
        .busy        (busy),
        .op_valid    (op_valid),
        .operands    (operands)
    );

    exec_alu #(
        .XLEN (XLEN)
    ) exec_alu_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .op_valid  (op_valid),
        .operands  (operands),
        .busy      (busy),
        .res_valid (res_valid),
        .result    (result)
    );

endmodule

// File: verif/exec_unit_tb.sv
`timescale 1ns/1ps

module exec_unit_tb;

    localparam int XLEN = 64;
    // issued operations over all tests, each given XLEN+10 cycles by the watchdog
    localparam int TEST_OPS = 31 * 12 + 16 + 16 + 7 + 2;
    localparam logic [63:0] MIN_VAL = 64'h8000_0000_0000_0000;
    localparam logic [63:0] ALL_ONES = 64'hffff_ffff_ffff_ffff;

    logic              clk;
    logic              rst_n;
    logic              flush;
    logic              issue_valid;
    exec_pkg::issue_t  issue;
    logic              busy;
    logic              res_valid;
    exec_pkg::result_t result;
    logic [15:0]       lfsr_state = 16'd145;

    exec_unit #(
        .XLEN (XLEN)
    ) exec_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue       (issue),
        .busy        (busy),
        .res_valid   (res_valid),
        .result      (result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (TEST_OPS * (XLEN + 10)) @(posedge clk);
        $display("watchdog expired, the DUT stopped responding");
        $display("Simulation failed");
        $fatal(1);
    end

    // galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic logic [63:0] random_word();
        logic [63:0] w;
        w = '0;
        for (int i = 0; i < 64; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[i] = lfsr_state[0];
        end
        return w;
    endfunction

    function automatic exec_pkg::issue_t random_issue(exec_pkg::alu_op_e op,
                                                      exec_pkg::sel_a_e sel_a,
                                                      exec_pkg::sel_b_e sel_b, logic word);
        exec_pkg::issue_t iss;
        iss.op = op;
        iss.pc = random_word();
        iss.rs1 = random_word();
        iss.rs2 = random_word();
        iss.csr = random_word();
        iss.imm = random_word();
        iss.sel_a = sel_a;
        iss.sel_b = sel_b;
        iss.word = word;
        return iss;
    endfunction

    // reference model built from the operation rules
    function automatic logic [63:0] expected_result(exec_pkg::issue_t iss);
        logic [63:0]        a;
        logic [63:0]        b;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [31:0] w;
        logic [63:0]        r;
        int                 sh;
        if (iss.sel_a == exec_pkg::sel_a_rs1) begin
            a = iss.word ? {32'd0, iss.rs1[31:0]} : iss.rs1;
        end else begin
            a = iss.pc;
        end
        case (iss.sel_b)
            exec_pkg::sel_b_rs2: b = iss.rs2;
            exec_pkg::sel_b_csr: b = iss.csr;
            default:             b = iss.imm;
        endcase
        sa = a;
        sb = b;
        sh = int'(b[5:0]);
        case (iss.op)
            exec_pkg::op_add:    r = a + b;
            exec_pkg::op_sub:    r = a - b;
            exec_pkg::op_pass_a: r = a;
            exec_pkg::op_pass_b: r = b;
            exec_pkg::op_xor:    r = a ^ b;
            exec_pkg::op_or:     r = a | b;
            exec_pkg::op_and:    r = a & b;
            exec_pkg::op_sll:    r = a << sh;
            exec_pkg::op_srl:    r = a >> sh;
            exec_pkg::op_sra: begin
                if (iss.word) begin
                    // one sign-filling shift per step on the low word
                    w = a[31:0];
                    for (int i = 0; i < sh; i++) begin
                        w = {w[31], w[31:1]};
                    end
                    r = {32'd0, w};
                end else begin
                    r = sa >>> sh;
                end
            end
            exec_pkg::op_slt:    r = (sa < sb) ? 64'd1 : 64'd0;
            exec_pkg::op_sltu:   r = (a < b) ? 64'd1 : 64'd0;
            exec_pkg::op_eq:     r = (a == b) ? 64'd1 : 64'd0;
            exec_pkg::op_ge:     r = (sa >= sb) ? 64'd1 : 64'd0;
            exec_pkg::op_geu:    r = (a >= b) ? 64'd1 : 64'd0;
            exec_pkg::op_mul:    r = a * b;
            exec_pkg::op_div: begin
                if (b == 64'd0) r = ALL_ONES;
                else if (a == MIN_VAL && b == ALL_ONES) r = MIN_VAL;
                else r = sa / sb;
            end
            exec_pkg::op_divu:   r = (b == 64'd0) ? ALL_ONES : a / b;
            exec_pkg::op_rem: begin
                if (b == 64'd0) r = a;
                else if (a == MIN_VAL && b == ALL_ONES) r = 64'd0;
                else r = sa % sb;
            end
            exec_pkg::op_remu:   r = (b == 64'd0) ? a : a % b;
            default:             r = 64'd0;
        endcase
        return r;
    endfunction

    task automatic stop_with_error(string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_cond(logic cond, string what);
        assert (cond === 1'b1) else stop_with_error(what);
    endtask

    task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
        assert (act === exp) else
            stop_with_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    // inputs change 2 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    // single-cycle op, result strobe exactly two edges after the issue
    task automatic run_single(string name, exec_pkg::issue_t iss);
        issue = iss;
        issue_valid = 1'b1;
        step_cycle();
        issue_valid = 1'b0;
        check_cond(!res_valid, {name, ": result strobe one cycle early"});
        step_cycle();
        check_cond(res_valid, {name, ": result strobe missing two cycles after issue"});
        check_value(name, expected_result(iss), result.res);
    endtask

    task automatic test_single_cycle();
        for (int code = 0; code < 32; code++) begin
            if (code == 15) continue;
            for (int sa = 0; sa < 2; sa++) begin
                for (int sb = 0; sb < 3; sb++) begin
                    for (int w = 0; w < 2; w++) begin
                        run_single("test_single_cycle",
                                   random_issue(exec_pkg::alu_op_e'(code), exec_pkg::sel_a_e'(sa),
                                                exec_pkg::sel_b_e'(sb), w[0]));
                    end
                end
            end
        end
    endtask

    task automatic test_back_to_back();
        exec_pkg::issue_t iss;
        logic [63:0]      expected[$];
        for (int k = 0; k <= 16; k++) begin
            if (k < 16) begin
                iss = random_issue(exec_pkg::alu_op_e'(k % 15), exec_pkg::sel_a_rs1,
                                   exec_pkg::sel_b_rs2, 1'b0);
                issue = iss;
                issue_valid = 1'b1;
                expected.push_back(expected_result(iss));
            end else begin
                issue_valid = 1'b0;
            end
            step_cycle();
            if (k >= 1) begin
                check_cond(res_valid, "test_back_to_back: a result slot came up empty");
                check_value("test_back_to_back", expected.pop_front(), result.res);
            end
        end
        step_cycle();
        check_cond(!res_valid, "test_back_to_back: more results than issued ops");
    endtask

    task automatic test_divide_corners();
        exec_pkg::issue_t iss;
        for (int code = 16; code < 20; code++) begin
            for (int c = 0; c < 4; c++) begin
                iss = random_issue(exec_pkg::alu_op_e'(code), exec_pkg::sel_a_rs1,
                                   exec_pkg::sel_b_rs2, 1'b0);
                case (c)
                    0: iss.rs2 = 64'd0;
                    1: begin
                        iss.rs1 = MIN_VAL;
                        iss.rs2 = ALL_ONES;
                    end
                    2: begin
                        iss.rs1 = ALL_ONES;
                        iss.rs2 = 64'd0;
                    end
                    default: ;
                endcase
                run_single("test_divide_corners", iss);
            end
        end
    endtask

    task automatic run_multiply(exec_pkg::issue_t iss, logic extra_issue);
        logic [63:0] expected;
        int          waited;
        expected = expected_result(iss);
        issue = iss;
        issue_valid = 1'b1;
        step_cycle();
        issue_valid = 1'b0;
        step_cycle();
        check_cond(busy, "test_multiply: busy did not rise after a multiply was issued");
        if (extra_issue) begin
            // dropped by the DUT while busy
            issue = random_issue(exec_pkg::op_add, exec_pkg::sel_a_rs1, exec_pkg::sel_b_rs2, 1'b0);
            issue_valid = 1'b1;
            step_cycle();
            issue_valid = 1'b0;
        end
        waited = 0;
        while (!res_valid) begin
            check_cond(busy, "test_multiply: busy fell before the product was ready");
            check_cond(waited < XLEN + 10, "test_multiply: product did not arrive in time");
            step_cycle();
            waited++;
        end
        check_cond(!busy, "test_multiply: busy still high with the result strobe");
        check_value("test_multiply", expected, result.res);
        repeat (2) begin
            step_cycle();
            check_cond(!res_valid, "test_multiply: extra result after the product");
        end
    endtask

    task automatic test_multiply();
        exec_pkg::issue_t iss;
        for (int k = 0; k < 7; k++) begin
            iss = random_issue(exec_pkg::op_mul, exec_pkg::sel_a_rs1, exec_pkg::sel_b_rs2, 1'b0);
            case (k)
                3: iss.rs1 = 64'd0;
                4: begin
                    iss.rs1 = ALL_ONES;
                    iss.rs2 = ALL_ONES;
                end
                5: iss.rs1 = 64'd1;
                6: iss.rs2 = 64'd1;
                default: ;
            endcase
            run_multiply(iss, k[0]);
        end
    endtask

    task automatic test_flush();
        issue = random_issue(exec_pkg::op_mul, exec_pkg::sel_a_rs1, exec_pkg::sel_b_rs2, 1'b0);
        issue_valid = 1'b1;
        step_cycle();
        issue_valid = 1'b0;
        repeat (XLEN / 2) step_cycle();
        check_cond(busy, "test_flush: busy not high before the flush");
        flush = 1'b1;
        step_cycle();
        flush = 1'b0;
        check_cond(!busy && !res_valid, "test_flush: flush did not abort the multiply");
        repeat (XLEN + 10) begin
            step_cycle();
            check_cond(!res_valid, "test_flush: a result appeared after the flush");
        end
        run_single("test_flush",
                   random_issue(exec_pkg::op_add, exec_pkg::sel_a_rs1, exec_pkg::sel_b_rs2, 1'b0));
    endtask

    initial begin
        rst_n = 1'b0;
        flush = 1'b0;
        issue_valid = 1'b0;
        issue = '0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_cond(!busy && !res_valid && result.res == 64'd0, "outputs not cleared by reset");
        test_single_cycle();
        test_back_to_back();
        test_divide_corners();
        test_multiply();
        test_flush();
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: exec_unit.f
logic/exec_pkg.sv
logic/operand_select.sv
logic/iter_multiplier.sv
logic/exec_alu.sv
logic/exec_unit.sv
verif/exec_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --timescale 1ns/1ps --top-module exec_unit_tb \
    -f exec_unit.f -o exec_unit_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/exec_unit_sim)
echo "$out"
echo "$out" | grep -q "^Simulation passed$" && exit 0 || exit 1
